// File: hw/exu_defs.svh
// Architectural constants of the execute stage
// RV32 only, so all widths here are fixed and not meant to be changed
// Trap target is a fixed vector since there is no CSR block
// Include freely, the guard keeps a single copy

`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// --------------------
// Widths
// --------------------

// Data and PC width
`define EXU_XLEN          32

// Register file address, x0..x31
`define EXU_RF_AWIDTH     5

// --------------------
// PC constants
// --------------------

// First PC fetched after reset
`define EXU_RST_VECTOR    32'h0000_0200

// Common target for every exception
`define EXU_TRAP_VECTOR   32'h0000_0100

// Clears bit 0 of jump and branch targets (JALR rule)
`define EXU_JUMP_MASK     32'hFFFF_FFFE

`endif // EXU_DEFS_SVH

// File: hw/exu_pkg.sv
// Shared types of the execute stage
// Enum encodings are part of the decode interface, keep them in sync
// Struct field order defines the packed bit layout seen at the ports

`default_nettype none

`include "exu_defs.svh"

package exu_pkg;

    // --------------------
    // Command encodings
    // --------------------

    typedef enum logic [4:0] {
        IALU_CMD_NONE = 5'd0,
        IALU_CMD_ADD  = 5'd1,
        IALU_CMD_SUB  = 5'd2,
        IALU_CMD_AND  = 5'd3,
        IALU_CMD_OR   = 5'd4,
        IALU_CMD_XOR  = 5'd5,
        IALU_CMD_SLL  = 5'd6,
        IALU_CMD_SRL  = 5'd7,
        IALU_CMD_SRA  = 5'd8,
        IALU_CMD_SLT  = 5'd9,
        IALU_CMD_SLTU = 5'd10,
        IALU_CMD_EQ   = 5'd11,  // Branch compares from here on
        IALU_CMD_NE   = 5'd12,
        IALU_CMD_LT   = 5'd13,
        IALU_CMD_GE   = 5'd14,
        IALU_CMD_LTU  = 5'd15,
        IALU_CMD_GEU  = 5'd16
    } ialu_cmd_e;

    typedef enum logic {
        IALU_OP_REG_REG = 1'b0, // op2 = rs2
        IALU_OP_REG_IMM = 1'b1  // op2 = imm
    } ialu_op_e;

    typedef enum logic {
        SUM2_OP_REG_IMM = 1'b0, // rs1 + imm
        SUM2_OP_PC_IMM  = 1'b1  // pc + imm
    } sum2_op_e;

    typedef enum logic [2:0] {
        RD_WB_NONE   = 3'd0,
        RD_WB_IALU   = 3'd1,
        RD_WB_SUM2   = 3'd2,
        RD_WB_IMM    = 3'd3,
        RD_WB_INC_PC = 3'd4
    } rd_wb_sel_e;

    typedef enum logic [3:0] {
        EXC_CODE_INSTR_MISALIGN     = 4'd0,
        EXC_CODE_INSTR_ACCESS_FAULT = 4'd1,
        EXC_CODE_ILLEGAL_INSTR      = 4'd2,
        EXC_CODE_BREAKPOINT         = 4'd3,
        EXC_CODE_ECALL_M            = 4'd11
    } exc_code_e;

    // --------------------
    // Bundles
    // --------------------

    // Decoded command from decode, 65 bits
    typedef struct packed {
        ialu_cmd_e                 ialu_cmd;
        ialu_op_e                  ialu_op;
        sum2_op_e                  sum2_op;
        rd_wb_sel_e                rd_wb_sel;
        logic [`EXU_RF_AWIDTH-1:0] rs1_addr;
        logic [`EXU_RF_AWIDTH-1:0] rs2_addr;
        logic [`EXU_RF_AWIDTH-1:0] rd_addr;
        logic [`EXU_XLEN-1:0]      imm;
        logic                      jump_req;   // JAL / JALR
        logic                      branch_req; // Conditional branch
        logic                      fencei_req; // Refetch from PC+4
        logic                      exc_req;    // Exception found by decode
        exc_code_e                 exc_code;
    } exu_cmd_s;

    typedef struct packed {
        logic                      req;
        logic [`EXU_RF_AWIDTH-1:0] addr;
        logic [`EXU_XLEN-1:0]      data;
    } mprf_wr_s;

    typedef struct packed {
        logic                 req;
        logic [`EXU_XLEN-1:0] pc;
    } pc_new_s;

    typedef struct packed {
        logic                 take;
        exc_code_e            code;
        logic [`EXU_XLEN-1:0] trap_val;
    } exc_s;

endpackage : exu_pkg

`default_nettype wire

// File: hw/exu_queue.sv
// One-entry command register in front of the execute logic
// No back-pressure, a command is taken at every edge with req_i high
// A flush at the same edge drops the incoming command for good
// Held command keeps its old value while valid_o is low

`default_nettype none

module exu_queue
    import exu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    // Decode side
    input  logic     req_i,    // Command strobe
    input  exu_cmd_s cmd_i,
    input  logic     flush_i,  // Redirect, drop the incoming command
    // Execute side
    output logic     valid_o,  // Held command executes this cycle
    output exu_cmd_s cmd_o
);

    logic     accept;
    logic     valid_ff;
    exu_cmd_s cmd_ff;

    // --------------------
    // Acceptance
    // --------------------

    assign accept = req_i & ~flush_i;

    // Valid flag, follows acceptance every edge
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            valid_ff <= 1'b0;
        end else begin
            valid_ff <= accept;
        end
    end

    // --------------------
    // Command register
    // --------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_ff <= cmd_i;  // Whole bundle at once
        end
    end

    assign valid_o = valid_ff;
    assign cmd_o   = cmd_ff;

endmodule : exu_queue

`default_nettype wire

// File: hw/exu_ialu.sv
// Integer ALU with a separate address adder, purely combinational
// Shifts use the low 5 bits of the second operand only
// cmp_o is meaningful for EQ..GEU, it is zero for every other command
// Compare commands also return the flag zero-extended on main_res_o

`default_nettype none

`include "exu_defs.svh"

module exu_ialu
    import exu_pkg::*;
(
    input  exu_cmd_s             cmd_i,
    input  logic [`EXU_XLEN-1:0] rs1_data_i,
    input  logic [`EXU_XLEN-1:0] rs2_data_i,
    input  logic [`EXU_XLEN-1:0] pc_i,        // Current PC for AUIPC / JAL / branches
    output logic [`EXU_XLEN-1:0] main_res_o,
    output logic                 cmp_o,
    output logic [`EXU_XLEN-1:0] addr_res_o
);

    logic        [`EXU_XLEN-1:0] main_op1;
    logic        [`EXU_XLEN-1:0] main_op2;
    logic signed [`EXU_XLEN-1:0] main_op1_s;  // Signed view for SRA
    logic        [`EXU_XLEN-1:0] addr_op1;
    logic        [4:0]           shamt;
    logic                        op_eq;
    logic                        op_lt_s;
    logic                        op_lt_u;

    // --------------------
    // Operand selection
    // --------------------

    assign main_op1 = rs1_data_i;
    assign main_op2 = (cmd_i.ialu_op == IALU_OP_REG_IMM) ? cmd_i.imm : rs2_data_i;

    // Address base
    assign addr_op1 = (cmd_i.sum2_op == SUM2_OP_PC_IMM) ? pc_i : rs1_data_i;

    assign main_op1_s = main_op1;
    assign shamt      = main_op2[4:0];

    // Shared comparator terms
    assign op_eq   = (main_op1 == main_op2);
    assign op_lt_s = ($signed(main_op1) < $signed(main_op2));
    assign op_lt_u = (main_op1 < main_op2);

    // --------------------
    // Branch comparator
    // --------------------

    always_comb begin
        case (cmd_i.ialu_cmd)
            IALU_CMD_EQ  : cmp_o = op_eq;
            IALU_CMD_NE  : cmp_o = ~op_eq;
            IALU_CMD_LT  : cmp_o = op_lt_s;
            IALU_CMD_GE  : cmp_o = ~op_lt_s;
            IALU_CMD_LTU : cmp_o = op_lt_u;
            IALU_CMD_GEU : cmp_o = ~op_lt_u;
            default      : cmp_o = 1'b0;   // Not a compare
        endcase
    end

    // --------------------
    // Main ALU
    // --------------------

    always_comb begin
        case (cmd_i.ialu_cmd)
            IALU_CMD_ADD  : main_res_o = main_op1 + main_op2;
            IALU_CMD_SUB  : main_res_o = main_op1 - main_op2;
            IALU_CMD_AND  : main_res_o = main_op1 & main_op2;
            IALU_CMD_OR   : main_res_o = main_op1 | main_op2;
            IALU_CMD_XOR  : main_res_o = main_op1 ^ main_op2;
            IALU_CMD_SLL  : main_res_o = main_op1 << shamt;
            IALU_CMD_SRL  : main_res_o = main_op1 >> shamt;
            IALU_CMD_SRA  : main_res_o = main_op1_s >>> shamt;  // Sign fill
            IALU_CMD_SLT  : main_res_o = {{(`EXU_XLEN-1){1'b0}}, op_lt_s};
            IALU_CMD_SLTU : main_res_o = {{(`EXU_XLEN-1){1'b0}}, op_lt_u};
            IALU_CMD_EQ,
            IALU_CMD_NE,
            IALU_CMD_LT,
            IALU_CMD_GE,
            IALU_CMD_LTU,
            IALU_CMD_GEU  : main_res_o = {{(`EXU_XLEN-1){1'b0}}, cmp_o};
            default       : main_res_o = '0;                   // NONE
        endcase
    end

    // --------------------
    // Address adder
    // --------------------

    // Runs beside the main ALU, branches need both at once
    assign addr_res_o = addr_op1 + cmd_i.imm;

endmodule : exu_ialu

`default_nettype wire

// File: hw/exu_pc.sv
// PC logic: start-up redirect, current PC register and new-PC select
// PC always steps by 4, no compressed instructions
// Start redirect fires once, three cycles after reset release
// Exception target is the fixed trap vector

`default_nettype none

`include "exu_defs.svh"

module exu_pc
    import exu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_i,     // Command executes, also the retire strobe
    input  exu_cmd_s             cmd_i,
    input  logic                 cmp_i,       // Branch condition from the ALU
    input  logic [`EXU_XLEN-1:0] addr_res_i,
    input  exc_s                 exc_i,
    output logic [`EXU_XLEN-1:0] pc_curr_o,
    output logic [`EXU_XLEN-1:0] inc_pc_o,    // PC+4
    output logic [`EXU_XLEN-1:0] jb_new_pc_o,
    output logic                 jb_taken_o,
    output pc_new_s              pc_new_o
);

    logic [3:0]           init_pc_v;
    logic                 init_pc;
    logic [`EXU_XLEN-1:0] inc_pc;
    logic                 jb_taken;
    logic [`EXU_XLEN-1:0] jb_new_pc;
    logic                 pc_new_req;
    logic [`EXU_XLEN-1:0] pc_new_pc;
    logic [`EXU_XLEN-1:0] pc_curr_ff;
    logic [`EXU_XLEN-1:0] pc_curr_next;

    // --------------------
    // Start sequence
    // --------------------

    // Fills with ones, then holds
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            init_pc_v <= '0;
        end else if (~&init_pc_v) begin
            init_pc_v <= {init_pc_v[2:0], 1'b1};
        end
    end

    assign init_pc = init_pc_v[2] & ~init_pc_v[3];  // One-cycle pulse

    // --------------------
    // Jumps and branches
    // --------------------

    assign jb_taken  = cmd_i.jump_req | (cmd_i.branch_req & cmp_i);
    assign jb_new_pc = addr_res_i & `EXU_JUMP_MASK;

    // --------------------
    // New PC select
    // --------------------

    always_comb begin
        case (1'b1)
            init_pc                    : pc_new_pc = `EXU_RST_VECTOR;
            exc_i.take                 : pc_new_pc = `EXU_TRAP_VECTOR;
            valid_i & cmd_i.fencei_req : pc_new_pc = inc_pc;    // Refetch next
            default                    : pc_new_pc = jb_new_pc;
        endcase
    end

    assign pc_new_req = init_pc | exc_i.take
                      | (valid_i & cmd_i.fencei_req)
                      | (valid_i & jb_taken);

    // --------------------
    // Current PC register
    // --------------------

    assign inc_pc = pc_curr_ff + `EXU_XLEN'd4;

    // Upper bits only move on a carry out of bit 5
    assign pc_curr_next = pc_new_req                  ? pc_new_pc
                        : (inc_pc[6] ^ pc_curr_ff[6]) ? inc_pc
                        : {pc_curr_ff[`EXU_XLEN-1:6], inc_pc[5:0]};

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pc_curr_ff <= `EXU_RST_VECTOR;
        end else if (valid_i) begin      // Every retire
            pc_curr_ff <= pc_curr_next;
        end
    end

    assign pc_curr_o   = pc_curr_ff;
    assign inc_pc_o    = inc_pc;
    assign jb_new_pc_o = jb_new_pc;
    assign jb_taken_o  = jb_taken;
    assign pc_new_o    = '{req: pc_new_req, pc: pc_new_pc};

endmodule : exu_pc

`default_nettype wire

// File: hw/exu_exc.sv
// Exception request, cause and trap value, purely combinational
// Decode-detected exceptions win over a jump misalign fault
// Code and trap value are only meaningful while take is high

`default_nettype none

`include "exu_defs.svh"

module exu_exc
    import exu_pkg::*;
(
    input  logic                 valid_i,
    input  exu_cmd_s             cmd_i,
    input  logic                 jb_taken_i,
    input  logic [`EXU_XLEN-1:0] jb_new_pc_i,  // Masked jump/branch target
    input  logic [`EXU_XLEN-1:0] pc_curr_i,
    output exc_s                 exc_o
);

    logic                 jb_misalign;
    exc_code_e            exc_code;
    logic [`EXU_XLEN-1:0] trap_val;

    // Target not on a word boundary
    assign jb_misalign = valid_i & jb_taken_i & (|jb_new_pc_i[1:0]);

    // Cause priority
    always_comb begin
        case (1'b1)
            cmd_i.exc_req : exc_code = cmd_i.exc_code;
            jb_misalign   : exc_code = EXC_CODE_INSTR_MISALIGN;
            default       : exc_code = EXC_CODE_ECALL_M;   // Unused, take is low
        endcase
    end

    always_comb begin
        case (exc_code)
            EXC_CODE_INSTR_MISALIGN     : trap_val = jb_new_pc_i;
            EXC_CODE_INSTR_ACCESS_FAULT : trap_val = pc_curr_i;
            EXC_CODE_ILLEGAL_INSTR      : trap_val = cmd_i.imm;  // Instruction bits from decode
            default                     : trap_val = '0;
        endcase
    end

    assign exc_o = '{take: (valid_i & cmd_i.exc_req) | jb_misalign,
                     code: exc_code,
                     trap_val: trap_val};

endmodule : exu_exc

`default_nettype wire

// File: hw/exu_top.sv
// Execute stage top, single-cycle execute behind a one-entry command register
// Register file read is asynchronous, data must return in the same cycle
// Commands offered while pc_new_o.req is high are dropped, decode resends
// Every valid command retires, with or without an exception

`default_nettype none

`include "exu_defs.svh"

module exu_top
    import exu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    // Decode
    input  logic                      req_i,
    input  exu_cmd_s                  cmd_i,
    // Register file
    output logic [`EXU_RF_AWIDTH-1:0] rs1_addr_o,
    output logic [`EXU_RF_AWIDTH-1:0] rs2_addr_o,
    input  logic [`EXU_XLEN-1:0]      rs1_data_i,
    input  logic [`EXU_XLEN-1:0]      rs2_data_i,
    output mprf_wr_s                  rf_wr_o,
    // Fetch and control
    output pc_new_s                   pc_new_o,
    output exc_s                      exc_o,
    output logic                      instret_o,
    output logic [`EXU_XLEN-1:0]      pc_curr_o
);

    logic                 valid;
    exu_cmd_s             cmd;
    logic [`EXU_XLEN-1:0] main_res;
    logic                 cmp;
    logic [`EXU_XLEN-1:0] addr_res;
    logic                 jb_taken;
    logic [`EXU_XLEN-1:0] jb_new_pc;
    logic [`EXU_XLEN-1:0] inc_pc;
    logic [`EXU_XLEN-1:0] pc_curr;
    exc_s                 exc;
    logic [`EXU_XLEN-1:0] rd_data;

    // --------------------
    // Submodules
    // --------------------

    exu_queue i_queue (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req_i),
        .cmd_i   (cmd_i),
        .flush_i (pc_new_o.req),  // Redirect drops the incoming command
        .valid_o (valid),
        .cmd_o   (cmd)
    );

    exu_ialu i_ialu (
        .cmd_i      (cmd),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .pc_i       (pc_curr),
        .main_res_o (main_res),
        .cmp_o      (cmp),
        .addr_res_o (addr_res)
    );

    exu_pc i_pc (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid),
        .cmd_i       (cmd),
        .cmp_i       (cmp),
        .addr_res_i  (addr_res),
        .exc_i       (exc),
        .pc_curr_o   (pc_curr),
        .inc_pc_o    (inc_pc),
        .jb_new_pc_o (jb_new_pc),
        .jb_taken_o  (jb_taken),
        .pc_new_o    (pc_new_o)
    );

    exu_exc i_exc (
        .valid_i     (valid),
        .cmd_i       (cmd),
        .jb_taken_i  (jb_taken),
        .jb_new_pc_i (jb_new_pc),
        .pc_curr_i   (pc_curr),
        .exc_o       (exc)
    );

    // --------------------
    // Write-back
    // --------------------

    always_comb begin
        case (cmd.rd_wb_sel)
            RD_WB_IALU   : rd_data = main_res;
            RD_WB_SUM2   : rd_data = addr_res;   // AUIPC
            RD_WB_IMM    : rd_data = cmd.imm;    // LUI
            RD_WB_INC_PC : rd_data = inc_pc;     // Link address
            default      : rd_data = '0;
        endcase
    end

    // No write when the command traps
    assign rf_wr_o = '{req: valid & (cmd.rd_wb_sel != RD_WB_NONE) & ~exc.take,
                       addr: cmd.rd_addr,
                       data: rd_data};

    assign rs1_addr_o = cmd.rs1_addr;
    assign rs2_addr_o = cmd.rs2_addr;
    assign exc_o      = exc;
    assign instret_o  = valid;
    assign pc_curr_o  = pc_curr;

endmodule : exu_top

`default_nettype wire

// File: bench/exu_assert.sv
// Protocol properties of the execute stage, bound into every exu_top
// Samples on the rising clock edge, reset checks need a running clock

`default_nettype none

module exu_assert
    import exu_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     req_i,
    input pc_new_s  pc_new_i,
    input exc_s     exc_i,
    input mprf_wr_s rf_wr_i,
    input logic     instret_i
);

    // --------------------
    // Write-back and redirect
    // --------------------

    // A trapping command never writes
    a_no_wr_on_trap: assert property (@(posedge clk) disable iff (!rst_n)
        !(rf_wr_i.req && exc_i.take))
        else $error("register write in the same cycle as a trap");

    // Command offered during a redirect is dropped
    a_drop_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        (pc_new_i.req && req_i) |=> !instret_i)
        else $error("command offered during a redirect retired");

    // --------------------
    // Reset
    // --------------------

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(instret_i || rf_wr_i.req || exc_i.take || pc_new_i.req))
        else $error("control output active while in reset");

endmodule : exu_assert

bind exu_top exu_assert i_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (req_i),
    .pc_new_i  (pc_new_o),
    .exc_i     (exc_o),
    .rf_wr_i   (rf_wr_o),
    .instret_i (instret_o)
);

`default_nettype wire

// File: bench/tb_exu.sv
// Testbench for the execute stage top level
// Commands come from a table with one idle cycle after each unless back-to-back
// Register file is modelled here and read asynchronously with x0 as zero
// x5 and x6 are ALU and branch sources and are never written
// Back-to-back rows must not follow each other directly in the table

`default_nettype none

`include "exu_defs.svh"

module tb_exu
    import exu_pkg::*;
();

    typedef struct packed {
        exu_cmd_s cmd;
        logic     b2b;   // Offered in the cycle after the previous row
        logic     drop;  // Lost to a redirect and never retires
    } row_s;

    typedef struct packed {
        mprf_wr_s             wr;
        pc_new_s              redir;
        exc_s                 exc;
        logic [`EXU_XLEN-1:0] next_pc;
    } expect_s;

    logic                      clk;
    logic                      rst_n;
    logic                      req;
    exu_cmd_s                  cmd;
    logic [`EXU_RF_AWIDTH-1:0] rs1_addr;
    logic [`EXU_RF_AWIDTH-1:0] rs2_addr;
    logic [`EXU_XLEN-1:0]      rs1_data;
    logic [`EXU_XLEN-1:0]      rs2_data;
    mprf_wr_s                  rf_wr;
    pc_new_s                   pc_new;
    exc_s                      exc;
    logic                      instret;
    logic [`EXU_XLEN-1:0]      pc_curr;

    logic [`EXU_XLEN-1:0] regs [32];    // Register file model
    logic [`EXU_XLEN-1:0] exp_pc;       // Model of pc_curr_o
    row_s                 rows [$];
    string                names [$];
    string                cur_name;
    integer               seed;
    int                   checks;
    int                   errors;
    int                   cycles = 0;
    int                   limit;

    exu_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req),
        .cmd_i      (cmd),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rf_wr_o    (rf_wr),
        .pc_new_o   (pc_new),
        .exc_o      (exc),
        .instret_o  (instret),
        .pc_curr_o  (pc_curr)
    );

    // --------------------
    // Clock, register file, timeout
    // --------------------

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // Period 40
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always @(posedge clk) begin
        if (rf_wr.req) begin
            regs[rf_wr.addr] <= rf_wr.data;  // Write lands at the end of the cycle
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------
    // Reference rules
    // --------------------

    function automatic logic [31:0] alu_result(ialu_cmd_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            IALU_CMD_ADD  : return a + b;
            IALU_CMD_SUB  : return a - b;
            IALU_CMD_AND  : return a & b;
            IALU_CMD_OR   : return a | b;
            IALU_CMD_XOR  : return a ^ b;
            IALU_CMD_SLL  : return a << b[4:0];
            IALU_CMD_SRL  : return a >> b[4:0];
            IALU_CMD_SRA  : return $unsigned($signed(a) >>> b[4:0]);
            IALU_CMD_SLT  : return {31'b0, $signed(a) < $signed(b)};
            IALU_CMD_SLTU : return {31'b0, a < b};
            default       : return '0;
        endcase
    endfunction

    function automatic logic branch_cond(ialu_cmd_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            IALU_CMD_EQ  : return a == b;
            IALU_CMD_NE  : return a != b;
            IALU_CMD_LT  : return $signed(a) < $signed(b);
            IALU_CMD_GE  : return $signed(a) >= $signed(b);
            IALU_CMD_LTU : return a < b;
            IALU_CMD_GEU : return a >= b;
            default      : return 1'b0;
        endcase
    endfunction

    // Expected outputs of one command executing at PC pc
    function automatic expect_s predict(exu_cmd_s c, logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] target;
        logic        taken;
        logic        misalign;
        expect_s     e;
        a        = (c.rs1_addr == '0) ? '0 : regs[c.rs1_addr];
        b        = (c.ialu_op == IALU_OP_REG_IMM) ? c.imm
                 : (c.rs2_addr == '0) ? '0 : regs[c.rs2_addr];
        addr     = ((c.sum2_op == SUM2_OP_PC_IMM) ? pc : a) + c.imm;
        target   = addr & `EXU_JUMP_MASK;
        taken    = c.jump_req | (c.branch_req & branch_cond(c.ialu_cmd, a, b));
        misalign = taken & (target[1:0] != 2'b00);
        e          = '0;
        e.exc.take = c.exc_req | misalign;
        e.exc.code = c.exc_req ? c.exc_code : EXC_CODE_INSTR_MISALIGN;
        case (e.exc.code)
            EXC_CODE_INSTR_MISALIGN     : e.exc.trap_val = target;
            EXC_CODE_INSTR_ACCESS_FAULT : e.exc.trap_val = pc;
            EXC_CODE_ILLEGAL_INSTR      : e.exc.trap_val = c.imm;
            default                     : e.exc.trap_val = '0;
        endcase
        case (c.rd_wb_sel)
            RD_WB_IALU   : e.wr.data = alu_result(c.ialu_cmd, a, b);
            RD_WB_SUM2   : e.wr.data = addr;
            RD_WB_IMM    : e.wr.data = c.imm;
            RD_WB_INC_PC : e.wr.data = pc + 32'd4;
            default      : e.wr.data = '0;
        endcase
        e.wr.req   = (c.rd_wb_sel != RD_WB_NONE) & ~e.exc.take;  // Trap kills the write
        e.wr.addr  = c.rd_addr;
        e.redir.req = e.exc.take | c.fencei_req | taken;
        e.redir.pc  = e.exc.take ? `EXU_TRAP_VECTOR
                    : c.fencei_req ? pc + 32'd4 : target;
        e.next_pc   = e.redir.req ? e.redir.pc : pc + 32'd4;
        return e;
    endfunction

    // --------------------
    // Stimulus table
    // --------------------

    function automatic exu_cmd_s new_cmd(ialu_cmd_e alu, ialu_op_e op, rd_wb_sel_e wb,
                                         logic [4:0] rs1, logic [4:0] rs2, logic [4:0] rd,
                                         logic [31:0] imm);
        exu_cmd_s c;
        c           = '0;      // Base rs1+imm and no control flags
        c.ialu_cmd  = alu;
        c.ialu_op   = op;
        c.rd_wb_sel = wb;
        c.rs1_addr  = rs1;
        c.rs2_addr  = rs2;
        c.rd_addr   = rd;
        c.imm       = imm;
        return c;
    endfunction

    task automatic add_row(input string name, input exu_cmd_s c, input logic b2b,
                           input logic drop);
        rows.push_back('{cmd: c, b2b: b2b, drop: drop});
        names.push_back(name);
    endtask

    task automatic build_table();
        exu_cmd_s  c;
        exu_cmd_s  add_c;
        ialu_cmd_e alu;
        add_c = new_cmd(IALU_CMD_ADD, IALU_OP_REG_REG, RD_WB_IALU, 5'd5, 5'd6, 5'd13, '0);
        // ALU register-register then register-immediate
        for (int k = 1; k <= 10; k++) begin
            alu = ialu_cmd_e'(k);
            add_row($sformatf("%s_rr", alu.name()),
                    new_cmd(alu, IALU_OP_REG_REG, RD_WB_IALU, 5'd5, 5'd6, 5'd10, '0),
                    1'b0, 1'b0);
            add_row($sformatf("%s_ri", alu.name()),
                    new_cmd(alu, IALU_OP_REG_IMM, RD_WB_IALU, 5'd6, 5'd0, 5'd11, $random(seed)),
                    1'b0, 1'b0);
        end
        add_row("lui", new_cmd(IALU_CMD_NONE, IALU_OP_REG_REG, RD_WB_IMM, 5'd0, 5'd0, 5'd12,
                               32'hABCD_E000), 1'b0, 1'b0);
        c = new_cmd(IALU_CMD_NONE, IALU_OP_REG_REG, RD_WB_SUM2, 5'd0, 5'd0, 5'd12, 32'h1_2000);
        c.sum2_op = SUM2_OP_PC_IMM;
        add_row("auipc", c, 1'b0, 1'b0);
        // Branch pairs x5/x5, x5/x6 and x6/x5 give both outcomes
        for (int k = 11; k <= 16; k++) begin
            alu = ialu_cmd_e'(k);
            for (int p = 0; p < 3; p++) begin
                c = new_cmd(alu, IALU_OP_REG_REG, RD_WB_NONE, (p == 2) ? 5'd6 : 5'd5,
                            (p == 1) ? 5'd6 : 5'd5, 5'd0, 32'h0000_0040);
                c.sum2_op    = SUM2_OP_PC_IMM;
                c.branch_req = 1'b1;
                add_row($sformatf("%s_%0d", alu.name(), p), c, 1'b0, 1'b0);
            end
        end
        // Jumps
        c = new_cmd(IALU_CMD_NONE, IALU_OP_REG_REG, RD_WB_INC_PC, 5'd0, 5'd0, 5'd1, 32'h100);
        c.sum2_op  = SUM2_OP_PC_IMM;
        c.jump_req = 1'b1;
        add_row("jal", c, 1'b0, 1'b0);
        add_row("jal_shadow", add_c, 1'b1, 1'b1);
        c.sum2_op = SUM2_OP_REG_IMM;
        c.imm     = 32'h0000_0301;   // Bit 0 masked off
        add_row("jalr", c, 1'b0, 1'b0);
        c.imm     = 32'h0000_0402;   // Bit 1 survives the mask
        add_row("jalr_misalign", c, 1'b0, 1'b0);
        add_row("misalign_shadow", add_c, 1'b1, 1'b1);
        // Follower executes since nothing redirects
        add_row("add_lead", add_c, 1'b0, 1'b0);
        add_row("sub_follow", new_cmd(IALU_CMD_SUB, IALU_OP_REG_REG, RD_WB_IALU, 5'd13, 5'd5,
                                      5'd14, '0), 1'b1, 1'b0);
        c = new_cmd(IALU_CMD_NONE, IALU_OP_REG_REG, RD_WB_NONE, 5'd0, 5'd0, 5'd0, '0);
        c.fencei_req = 1'b1;
        add_row("fence_i", c, 1'b0, 1'b0);
        // Exceptions found by decode
        c = new_cmd(IALU_CMD_ADD, IALU_OP_REG_IMM, RD_WB_IALU, 5'd5, 5'd0, 5'd10, 32'h7F3F);
        c.exc_req  = 1'b1;
        c.exc_code = EXC_CODE_ILLEGAL_INSTR;
        add_row("illegal", c, 1'b0, 1'b0);
        c.exc_code = EXC_CODE_INSTR_ACCESS_FAULT;
        add_row("access_fault", c, 1'b0, 1'b0);
        c.exc_code = EXC_CODE_BREAKPOINT;
        add_row("ebreak", c, 1'b0, 1'b0);
        c.exc_code = EXC_CODE_ECALL_M;
        add_row("ecall", c, 1'b0, 1'b0);
        add_row("ecall_shadow", add_c, 1'b1, 1'b1);
    endtask

    // --------------------
    // Checks and row sequencing
    // --------------------

    task automatic check(input string field, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
        checks++;
        assert (act_val === exp_val) else begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h", cur_name, field, exp_val, act_val);
        end
    endtask

    task automatic check_exec(input expect_s e);
        check("instret", 32'd1, 32'(instret));
        check("rf_wr.req", 32'(e.wr.req), 32'(rf_wr.req));
        if (e.wr.req) begin
            check("rf_wr.addr", 32'(e.wr.addr), 32'(rf_wr.addr));
            check("rf_wr.data", e.wr.data, rf_wr.data);
        end
        check("exc.take", 32'(e.exc.take), 32'(exc.take));
        if (e.exc.take) begin
            check("exc.code", 32'(e.exc.code), 32'(exc.code));
            check("exc.trap_val", e.exc.trap_val, exc.trap_val);
        end
        check("pc_new.req", 32'(e.redir.req), 32'(pc_new.req));
        if (e.redir.req) begin
            check("pc_new.pc", e.redir.pc, pc_new.pc);
        end
    endtask

    task automatic run_row(input int i);
        expect_s e;
        cur_name = names[i];
        if (!rows[i].b2b) begin
            @(posedge clk);
            req <= 1'b1;
            cmd <= rows[i].cmd;
            @(posedge clk);                                // Acceptance edge
            if (i + 1 < rows.size() && rows[i + 1].b2b) begin
                cmd <= rows[i + 1].cmd;                    // Next row right behind
            end else begin
                req <= 1'b0;
            end
            @(negedge clk);
        end
        if (rows[i].drop) begin
            check("instret", 32'd0, 32'(instret));
            check("rf_wr.req", 32'd0, 32'(rf_wr.req));
            e         = '0;
            e.next_pc = exp_pc;                            // Nothing retires
        end else begin
            e = predict(rows[i].cmd, exp_pc);
            check_exec(e);
        end
        @(posedge clk);                                    // Retire edge
        req <= 1'b0;
        @(negedge clk);
        check("pc_curr", e.next_pc, pc_curr);
        exp_pc = e.next_pc;
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        rst_n  = 1'b0;
        req    = 1'b0;
        cmd    = '0;
        seed   = 32'h1b7a3343;
        checks = 0;
        errors = 0;
        for (int r = 0; r < 32; r++) begin
            regs[r] = $random(seed);
        end
        regs[6] = regs[5] ^ 32'h8000_1234;  // Signed and unsigned order disagree
        build_table();
        limit = rows.size() * 3 + 40;

        // Start-up redirect in the third cycle after release
        cur_name = "reset";
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            check("pc_new.req", 32'(c == 3), 32'(pc_new.req));
            if (c == 3) begin
                check("pc_new.pc", `EXU_RST_VECTOR, pc_new.pc);
            end
            check("pc_curr", `EXU_RST_VECTOR, pc_curr);
            @(posedge clk);
        end
        exp_pc = `EXU_RST_VECTOR;

        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_exu

`default_nettype wire

// File: tb.f
+incdir+hw
hw/exu_pkg.sv
hw/exu_queue.sv
hw/exu_ialu.sv
hw/exu_pc.sv
hw/exu_exc.sv
hw/exu_top.sv
bench/exu_assert.sv
bench/tb_exu.sv

// File: Makefile
TOP := tb_exu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
